// File: tb.f
hdl/tau_pkg.sv
hdl/chunk_row_start.sv
hdl/row_skid_fifo.sv
hdl/chunk_row_split.sv
hdl/chunk_addr_looper.sv
sim/tb_chunk_addr_looper.sv

// File: Bender.yml
package:
  name: chunk_addr_looper

sources:
  - files:
      - hdl/tau_pkg.sv
      - hdl/chunk_row_start.sv
      - hdl/row_skid_fifo.sv
      - hdl/chunk_row_split.sv
      - hdl/chunk_addr_looper.sv
  - target: simulation
    files:
      - sim/tb_chunk_addr_looper.sv

// File: sim/tb_chunk_addr_looper.sv
module tb_chunk_addr_looper;

	localparam int RAND_REQS  = 20;
	localparam int TOTAL_REQS = RAND_REQS + 5;
	localparam logic [31:0] SEED = 32'h3a29_3d62;

	// Flattened command as it appears on the output link
	typedef struct packed {
		logic [1:0]                 ctype;
		logic                       islast;
		logic [tau_pkg::GBW-1:0]    addr;
		logic [tau_pkg::V_BW-1:0]   ofs;
		logic [tau_pkg::V_BW1-1:0]  len;
	} cmd_t;

	logic                        i_clk;
	logic                        i_arst_n;
	logic                        i_req_rdy;
	logic                        o_req_ack;
	logic [tau_pkg::GBW-1:0]     i_req_base;
	logic [tau_pkg::GBW-1:0]     i_req_stride;
	logic [tau_pkg::ROW_BW-1:0]  i_req_rows;
	logic [tau_pkg::LEN_BW-1:0]  i_req_len;
	logic [tau_pkg::ROW_BW-1:0]  i_req_bound;
	logic                        o_cmd_rdy;
	logic                        i_cmd_ack;
	tau_pkg::cmd_type_e          o_cmd_type;
	logic                        o_cmd_islast;
	logic [tau_pkg::GBW-1:0]     o_cmd_addr;
	logic [tau_pkg::V_BW-1:0]    o_cmd_addrofs;
	logic [tau_pkg::V_BW1-1:0]   o_cmd_len;

	cmd_t         exp_q[$];
	cmd_t         exp_head;
	logic         exp_valid;
	cmd_t         got;
	logic         req_seen;
	int           err_cnt;
	int           last_seen;
	int           last_expected;
	logic [31:0]  stim_state;
	logic [31:0]  ack_state;

	assign got = {o_cmd_type, o_cmd_islast, o_cmd_addr, o_cmd_addrofs, o_cmd_len};

	chunk_addr_looper dut (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_req_rdy     (i_req_rdy),
		.o_req_ack     (o_req_ack),
		.i_req_base    (i_req_base),
		.i_req_stride  (i_req_stride),
		.i_req_rows    (i_req_rows),
		.i_req_len     (i_req_len),
		.i_req_bound   (i_req_bound),
		.o_cmd_rdy     (o_cmd_rdy),
		.i_cmd_ack     (i_cmd_ack),
		.o_cmd_type    (o_cmd_type),
		.o_cmd_islast  (o_cmd_islast),
		.o_cmd_addr    (o_cmd_addr),
		.o_cmd_addrofs (o_cmd_addrofs),
		.o_cmd_len     (o_cmd_len)
	);

	always #5 i_clk = ~i_clk;

	//============================================================
	// Random source and reference model
	//============================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw(output logic [15:0] v);
		stim_state = lcg_next(stim_state);
		v = stim_state[31:16];
	endtask

	task automatic refresh_head();
		exp_valid = (exp_q.size() != 0);
		if (exp_valid) begin
			exp_head = exp_q[0];
		end else begin
			exp_head = '0;
		end
	endtask

	// Walk the rows and cut them at vector boundaries
	task automatic expect_request(
		input logic [tau_pkg::GBW-1:0]     base,
		input logic [tau_pkg::GBW-1:0]     stride,
		input logic [tau_pkg::ROW_BW-1:0]  rows,
		input logic [tau_pkg::LEN_BW-1:0]  len,
		input logic [tau_pkg::ROW_BW-1:0]  bound
	);
		cmd_t                     c;
		logic [tau_pkg::GBW-1:0]  p;
		int                       r;
		int                       left;
		int                       ofs;
		int                       n;
		for (r = 0; r < int'(rows); r++) begin
			p    = base + tau_pkg::GBW'(r) * stride;
			left = int'(len);
			while (left > 0) begin
				ofs = int'(p[tau_pkg::V_BW-1:0]);
				n   = tau_pkg::VSIZE - ofs;
				if (left < n) begin
					n = left;
				end
				c.ctype  = (r >= int'(bound)) ? tau_pkg::CMD_PAD : tau_pkg::CMD_READ;
				c.islast = (r == int'(rows) - 1) && (left == n);
				c.addr   = p - tau_pkg::GBW'(ofs);
				c.ofs    = tau_pkg::V_BW'(ofs);
				c.len    = tau_pkg::V_BW1'(n);
				exp_q.push_back(c);
				p    = p + tau_pkg::GBW'(n);
				left = left - n;
			end
		end
		refresh_head();
	endtask

	// Called on a falling edge, returns on the falling edge after the ack
	task automatic send_request(
		input logic [tau_pkg::GBW-1:0]     base,
		input logic [tau_pkg::GBW-1:0]     stride,
		input logic [tau_pkg::ROW_BW-1:0]  rows,
		input logic [tau_pkg::LEN_BW-1:0]  len,
		input logic [tau_pkg::ROW_BW-1:0]  bound
	);
		expect_request(base, stride, rows, len, bound);
		if (rows != '0) begin
			last_expected++;
		end
		req_seen     = 1'b1;
		i_req_rdy    = 1'b1;
		i_req_base   = base;
		i_req_stride = stride;
		i_req_rows   = rows;
		i_req_len    = len;
		i_req_bound  = bound;
		do begin
			@(posedge i_clk);
		end while (!o_req_ack);
		@(negedge i_clk);
		i_req_rdy = 1'b0;
	endtask

	// Consumer withholds ack about a third of the time
	always @(negedge i_clk) begin
		ack_state = lcg_next(ack_state);
		i_cmd_ack = (ack_state[31:16] % 3) != 0;
	end

	always @(posedge i_clk) begin
		if (i_arst_n && o_cmd_rdy && i_cmd_ack) begin
			if (o_cmd_islast) begin
				last_seen++;
			end
			if (exp_q.size() != 0) begin
				void'(exp_q.pop_front());
			end
			refresh_head();
		end
	end

	//============================================================
	// Checks
	//============================================================

	a_cmd_match: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_cmd_rdy && i_cmd_ack |-> exp_valid && got == exp_head
	) else begin
		err_cnt++;
		$display("** Error @%0t: command mismatch, got %h expected %h (queue valid %0b)",
			$time, $sampled(got), $sampled(exp_head), $sampled(exp_valid));
	end

	a_cmd_stable: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_cmd_rdy && !i_cmd_ack |=> o_cmd_rdy && $stable(got)
	) else begin
		err_cnt++;
		$display("** Error @%0t: command output moved while stalled", $time);
	end

	a_idle_start: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		!req_seen |-> !o_cmd_rdy && !o_req_ack
	) else begin
		err_cnt++;
		$display("** Error @%0t: output handshake active before any request", $time);
	end

	initial begin
		repeat (16 + TOTAL_REQS * 200) @(posedge i_clk);
		$display("Watchdog: the run timed out with %0d commands still expected", exp_q.size());
		$display("=== FAIL ===");
		$finish;
	end

	//============================================================
	// Stimulus
	//============================================================

	initial begin
		logic [15:0] v;
		logic [15:0] base;
		logic [15:0] stride;
		logic [15:0] rows;
		logic [15:0] len;
		logic [15:0] bound;
		int          k;
		i_clk         = 1'b0;
		i_arst_n      = 1'b0;
		i_req_rdy     = 1'b0;
		i_req_base    = '0;
		i_req_stride  = '0;
		i_req_rows    = '0;
		i_req_len     = '0;
		i_req_bound   = '0;
		i_cmd_ack     = 1'b0;
		req_seen      = 1'b0;
		err_cnt       = 0;
		last_seen     = 0;
		last_expected = 0;
		stim_state    = SEED;
		ack_state     = ~SEED;
		refresh_head();

		repeat (16) @(negedge i_clk);
		i_arst_n = 1'b1;
		repeat (4) @(negedge i_clk);

		// Aligned, unaligned, padded, empty and single-word requests
		send_request(16'h0100, 16'h0040, 4'd3, 6'd16, 4'd3);
		send_request(16'h0203, 16'h0025, 4'd2, 6'd13, 4'd2);
		send_request(16'h0400, 16'h0010, 4'd4, 6'd10, 4'd2);
		send_request(16'h0500, 16'h0008, 4'd0, 6'd5, 4'd0);
		send_request(16'h0607, 16'h0001, 4'd1, 6'd1, 4'd1);

		for (k = 0; k < RAND_REQS; k++) begin
			draw(base);
			draw(stride);
			draw(rows);
			draw(len);
			draw(bound);
			send_request(base, stride, tau_pkg::ROW_BW'(rows % 6),
				tau_pkg::LEN_BW'(1 + len % 24), tau_pkg::ROW_BW'(bound % 7));
			draw(v);
			repeat (v % 3) @(negedge i_clk);
		end

		while (exp_valid || o_cmd_rdy) begin
			@(negedge i_clk);
		end
		// Quiet tail so a stray extra command still hits the match check
		repeat (20) @(negedge i_clk);

		assert (last_seen == last_expected) else begin
			err_cnt++;
			$display("Final command count is wrong: saw %0d flagged commands for %0d requests",
				last_seen, last_expected);
		end

		$display("Summary: %0d errors, %0d commands left in the reference queue",
			err_cnt, exp_q.size());
		if (err_cnt == 0 && exp_q.size() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: hdl/chunk_addr_looper.sv
module chunk_addr_looper (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_req_rdy,
	output logic                         o_req_ack,
	input  logic [tau_pkg::GBW-1:0]      i_req_base,
	input  logic [tau_pkg::GBW-1:0]      i_req_stride,
	input  logic [tau_pkg::ROW_BW-1:0]   i_req_rows,
	input  logic [tau_pkg::LEN_BW-1:0]   i_req_len,
	input  logic [tau_pkg::ROW_BW-1:0]   i_req_bound,
	output logic                         o_cmd_rdy,
	input  logic                         i_cmd_ack,
	output tau_pkg::cmd_type_e           o_cmd_type,
	output logic                         o_cmd_islast,
	output logic [tau_pkg::GBW-1:0]      o_cmd_addr,
	output logic [tau_pkg::V_BW-1:0]     o_cmd_addrofs,
	output logic [tau_pkg::V_BW1-1:0]    o_cmd_len
);

	//==========================================================
	// Stage links
	//==========================================================

	logic                        s01_rdy, s01_ack;
	logic [tau_pkg::GBW-1:0]     s01_addr;
	logic [tau_pkg::LEN_BW-1:0]  s01_len;
	logic                        s01_pad, s01_rowlast;

	logic                        s12_rdy, s12_ack;
	logic [tau_pkg::GBW-1:0]     s12_addr;
	logic [tau_pkg::LEN_BW-1:0]  s12_len;
	logic                        s12_pad, s12_rowlast;

	logic                        s23_rdy, s23_ack;
	tau_pkg::cmd_type_e          s23_type;
	logic                        s23_islast;
	logic [tau_pkg::GBW-1:0]     s23_addr;
	logic [tau_pkg::V_BW-1:0]    s23_addrofs;
	logic [tau_pkg::V_BW1-1:0]   s23_len;

	chunk_row_start u_s0_row_start (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_req_rdy    (i_req_rdy),
		.i_req_base   (i_req_base),
		.i_req_stride (i_req_stride),
		.i_req_rows   (i_req_rows),
		.i_req_len    (i_req_len),
		.i_req_bound  (i_req_bound),
		.i_row_ack    (s01_ack),
		.o_req_ack    (o_req_ack),
		.o_row_rdy    (s01_rdy),
		.o_row_addr   (s01_addr),
		.o_row_len    (s01_len),
		.o_row_pad    (s01_pad),
		.o_row_last   (s01_rowlast)
	);

	row_skid_fifo u_s1_fifo (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_src_rdy  (s01_rdy),
		.i_src_addr (s01_addr),
		.i_src_len  (s01_len),
		.i_src_pad  (s01_pad),
		.i_src_last (s01_rowlast),
		.i_dst_ack  (s12_ack),
		.o_src_ack  (s01_ack),
		.o_dst_rdy  (s12_rdy),
		.o_dst_addr (s12_addr),
		.o_dst_len  (s12_len),
		.o_dst_pad  (s12_pad),
		.o_dst_last (s12_rowlast)
	);

	chunk_row_split u_s2_split (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_row_rdy     (s12_rdy),
		.i_row_addr    (s12_addr),
		.i_row_len     (s12_len),
		.i_row_pad     (s12_pad),
		.i_row_last    (s12_rowlast),
		.i_cmd_ack     (s23_ack),
		.o_row_ack     (s12_ack),
		.o_cmd_rdy     (s23_rdy),
		.o_cmd_type    (s23_type),
		.o_cmd_islast  (s23_islast),
		.o_cmd_addr    (s23_addr),
		.o_cmd_addrofs (s23_addrofs),
		.o_cmd_len     (s23_len)
	);

	//==========================================================
	// Output register
	//==========================================================

	// Empty or draining register takes a new command every cycle
	assign s23_ack = s23_rdy && (!o_cmd_rdy || i_cmd_ack);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_cmd_rdy <= 1'b0;
		end else if (s23_ack) begin
			o_cmd_rdy <= 1'b1;
		end else if (i_cmd_ack) begin
			o_cmd_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (s23_ack) begin
			o_cmd_type    <= s23_type;
			o_cmd_islast  <= s23_islast;
			o_cmd_addr    <= s23_addr;
			o_cmd_addrofs <= s23_addrofs;
			o_cmd_len     <= s23_len;
		end
	end

	// Downstream may sample late, so a stalled command must not move
	a_cmd_hold: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_cmd_rdy && !i_cmd_ack |=> o_cmd_rdy && $stable(o_cmd_type)
			&& $stable(o_cmd_islast) && $stable(o_cmd_addr)
			&& $stable(o_cmd_addrofs) && $stable(o_cmd_len)
	) else $error("command output changed under stall");

endmodule

// File: hdl/chunk_row_split.sv
module chunk_row_split (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_row_rdy,
	input  logic [tau_pkg::GBW-1:0]      i_row_addr,
	input  logic [tau_pkg::LEN_BW-1:0]   i_row_len,
	input  logic                         i_row_pad,
	input  logic                         i_row_last,
	input  logic                         i_cmd_ack,
	output logic                         o_row_ack,
	output logic                         o_cmd_rdy,
	output tau_pkg::cmd_type_e           o_cmd_type,
	output logic                         o_cmd_islast,
	output logic [tau_pkg::GBW-1:0]      o_cmd_addr,
	output logic [tau_pkg::V_BW-1:0]     o_cmd_addrofs,
	output logic [tau_pkg::V_BW1-1:0]    o_cmd_len
);

	//==========================================================
	// Walk state
	//==========================================================

	// Set once the first piece of the current row has gone out
	logic                        started;
	logic [tau_pkg::GBW-1:0]     cur_addr;
	logic [tau_pkg::LEN_BW-1:0]  left_r;

	logic [tau_pkg::GBW-1:0]     p;
	logic [tau_pkg::LEN_BW-1:0]  rem;
	logic [tau_pkg::V_BW-1:0]    ofs;
	logic [tau_pkg::V_BW1-1:0]   room;
	logic                        final_piece;

	//==========================================================
	// Command rule
	//==========================================================

	// First piece comes straight from the row descriptor
	assign p   = started ? cur_addr : i_row_addr;
	assign rem = started ? left_r : i_row_len;

	assign ofs  = p[tau_pkg::V_BW-1:0];
	assign room = tau_pkg::V_BW1'(tau_pkg::VSIZE) - tau_pkg::V_BW1'(ofs);

	// Whatever is left fits before the next vector boundary
	assign final_piece = (rem <= tau_pkg::LEN_BW'(room));

	assign o_cmd_rdy     = i_row_rdy;
	assign o_cmd_type    = i_row_pad ? tau_pkg::CMD_PAD : tau_pkg::CMD_READ;
	assign o_cmd_addr    = {p[tau_pkg::GBW-1:tau_pkg::V_BW], {tau_pkg::V_BW{1'b0}}};
	assign o_cmd_addrofs = ofs;
	assign o_cmd_len     = final_piece ? rem[tau_pkg::V_BW1-1:0] : room;
	assign o_cmd_islast  = i_row_last && final_piece;

	// Row is released together with its last piece
	assign o_row_ack = i_row_rdy && i_cmd_ack && final_piece;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			started <= 1'b0;
		end else if (o_cmd_rdy && i_cmd_ack) begin
			started <= !final_piece;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_cmd_rdy && i_cmd_ack && !final_piece) begin
			cur_addr <= p + tau_pkg::GBW'(o_cmd_len);
			left_r   <= rem - tau_pkg::LEN_BW'(o_cmd_len);
		end
	end

	//==========================================================
	// Checks
	//==========================================================

	// Zero-length rows are not part of the request format
	a_len_nonzero: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_cmd_rdy |-> o_cmd_len >= tau_pkg::V_BW1'(1)
	) else $error("split command with zero length");

	a_no_cross: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_cmd_rdy |-> (int'(o_cmd_addrofs) + int'(o_cmd_len)) <= tau_pkg::VSIZE
	) else $error("split command crosses a vector boundary");

endmodule

// File: hdl/row_skid_fifo.sv
module row_skid_fifo (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_src_rdy,
	input  logic [tau_pkg::GBW-1:0]      i_src_addr,
	input  logic [tau_pkg::LEN_BW-1:0]   i_src_len,
	input  logic                         i_src_pad,
	input  logic                         i_src_last,
	input  logic                         i_dst_ack,
	output logic                         o_src_ack,
	output logic                         o_dst_rdy,
	output logic [tau_pkg::GBW-1:0]      o_dst_addr,
	output logic [tau_pkg::LEN_BW-1:0]   o_dst_len,
	output logic                         o_dst_pad,
	output logic                         o_dst_last
);

	logic [1:0]                  cnt;
	logic                        push;
	logic                        pop;
	logic                        load_new0;
	logic                        load_nxt0;
	logic                        load_new1;
	logic [tau_pkg::GBW-1:0]     addr_q [2];
	logic [tau_pkg::LEN_BW-1:0]  len_q  [2];
	logic                        pad_q  [2];
	logic                        last_q [2];

	// Slot 0 is the head and slot 1 only fills behind it
	assign o_src_ack = i_src_rdy && (cnt != 2'd2);
	assign o_dst_rdy = (cnt != 2'd0);
	assign push      = o_src_ack;
	assign pop       = o_dst_rdy && i_dst_ack;

	assign load_new0 = push && (cnt == 2'd0 || pop);
	assign load_nxt0 = pop && (cnt == 2'd2);
	assign load_new1 = push && (cnt != 2'd0) && !pop;

	assign o_dst_addr = addr_q[0];
	assign o_dst_len  = len_q[0];
	assign o_dst_pad  = pad_q[0];
	assign o_dst_last = last_q[0];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt <= 2'd0;
		end else begin
			cnt <= cnt + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge i_clk) begin
		if (load_new0 || load_nxt0) begin
			addr_q[0] <= load_new0 ? i_src_addr : addr_q[1];
			len_q[0]  <= load_new0 ? i_src_len  : len_q[1];
			pad_q[0]  <= load_new0 ? i_src_pad  : pad_q[1];
			last_q[0] <= load_new0 ? i_src_last : last_q[1];
		end
		if (load_new1) begin
			addr_q[1] <= i_src_addr;
			len_q[1]  <= i_src_len;
			pad_q[1]  <= i_src_pad;
			last_q[1] <= i_src_last;
		end
	end

	a_fill_bound: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		cnt <= 2'd2
	) else $error("row fifo overfilled");

endmodule

// File: hdl/chunk_row_start.sv
module chunk_row_start (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_req_rdy,
	input  logic [tau_pkg::GBW-1:0]      i_req_base,
	input  logic [tau_pkg::GBW-1:0]      i_req_stride,
	input  logic [tau_pkg::ROW_BW-1:0]   i_req_rows,
	input  logic [tau_pkg::LEN_BW-1:0]   i_req_len,
	input  logic [tau_pkg::ROW_BW-1:0]   i_req_bound,
	input  logic                         i_row_ack,
	output logic                         o_req_ack,
	output logic                         o_row_rdy,
	output logic [tau_pkg::GBW-1:0]      o_row_addr,
	output logic [tau_pkg::LEN_BW-1:0]   o_row_len,
	output logic                         o_row_pad,
	output logic                         o_row_last
);

	//==========================================================
	// Internal state
	//==========================================================

	logic                        busy;
	logic [tau_pkg::ROW_BW-1:0]  row_cnt;
	logic [tau_pkg::ROW_BW-1:0]  last_idx;
	logic [tau_pkg::ROW_BW-1:0]  bound_r;
	logic [tau_pkg::GBW-1:0]     stride_r;
	logic [tau_pkg::GBW-1:0]     row_addr;
	logic [tau_pkg::LEN_BW-1:0]  len_r;

	// Idle looper takes the request at once
	assign o_req_ack = i_req_rdy && !busy;

	assign o_row_rdy  = busy;
	assign o_row_addr = row_addr;
	assign o_row_len  = len_r;
	assign o_row_pad  = (row_cnt >= bound_r);
	assign o_row_last = (row_cnt == last_idx);

	//==========================================================
	// Row walk
	//==========================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy    <= 1'b0;
			row_cnt <= '0;
		end else if (o_req_ack) begin
			// Zero rows is accepted and dropped
			busy    <= (i_req_rows != '0);
			row_cnt <= '0;
		end else if (i_row_ack) begin
			if (o_row_last) begin
				busy <= 1'b0;
			end
			row_cnt <= row_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_req_ack) begin
			row_addr <= i_req_base;
			stride_r <= i_req_stride;
			len_r    <= i_req_len;
			bound_r  <= i_req_bound;
			last_idx <= i_req_rows - 1'b1;
		end else if (i_row_ack) begin
			// Next row starts one stride further on
			row_addr <= row_addr + stride_r;
		end
	end

	//==========================================================
	// Checks
	//==========================================================

	// A row on offer stays put until the fifo takes it
	a_row_hold: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_row_rdy && !i_row_ack |=> o_row_rdy && $stable(o_row_addr)
			&& $stable(o_row_len) && $stable(o_row_pad) && $stable(o_row_last)
	) else $error("row descriptor changed before ack");

endmodule

// File: hdl/tau_pkg.sv
package tau_pkg;

	//==========================================================
	// Address and vector sizes
	//==========================================================

	// Global word address width
	localparam int GBW = 16;

	// Words in one vector line
	// Commands never straddle a line
	localparam int VSIZE = 8;

	// Word offset inside a vector line
	localparam int V_BW = $clog2(VSIZE);

	// Command length from 1 to VSIZE inclusive
	localparam int V_BW1 = $clog2(VSIZE + 1);

	//==========================================================
	// Request limits
	//==========================================================

	// Row count and row index up to 15 rows
	localparam int ROW_BW = 4;

	// Words per row from 1 to 63
	localparam int LEN_BW = 6;

	//==========================================================
	// Command types
	//==========================================================

	// READ fetches from memory
	// PAD supplies zeros and never touches the memory port
	typedef enum logic [1:0] {
		CMD_READ = 2'd0,
		CMD_PAD  = 2'd1
	} cmd_type_e;

endpackage
